// ==== Makefile ====
TOP = tb_pool_thresh

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) \
		--Mdir obj_dir -o sim
	./obj_dir/sim

lint:
	verilator --lint-only --timing -Wall -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== compile.f ====
+incdir+hw
hw/pool_thresh_pkg.sv
hw/thre_apb_regs.sv
hw/pool_window.sv
hw/chan_binarize.sv
hw/pool_thresh_top.sv
test/pool_thresh_assert.sv
test/tb_pool_thresh.sv

// ==== hw/chan_binarize.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pool_thresh_config.svh"

module chan_binarize import pool_thresh_pkg::*; (
    input  wire      clk,
    input  wire      o_0_val,
    input  wire      i_win_vld,
    input  sample_t  i_win [`POOL_WINDOW],
    input  sample_t  i_thre,
    output logic     o_bin,
    output logic     o_bin_vld
);

    ////////////////////////////////////////////////////////////////////////////
    // Window maximum
    ////////////////////////////////////////////////////////////////////////////

    sample_t win_max;

    // Signed compare, sample_t carries the sign
    always_comb begin
        win_max = i_win[0];
        for (int i = 1; i < `POOL_WINDOW; i++) begin
            if (i_win[i] > win_max) begin
                win_max = i_win[i];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Threshold compare
    ////////////////////////////////////////////////////////////////////////////

    logic hit;

    // Equal to the threshold counts as a one
    assign hit = (win_max >= i_thre);

    always_ff @(posedge clk or negedge o_0_val) begin
        if (!o_0_val) begin
            o_bin     <= 1'b0;
            o_bin_vld <= 1'b0;
        end else begin
            o_bin_vld <= i_win_vld;
            // Hold the last result between strides
            if (i_win_vld) begin
                o_bin <= hit;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/pool_thresh_config.svh ====
`ifndef POOL_THRESH_CONFIG_SVH
`define POOL_THRESH_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath sizes
////////////////////////////////////////////////////////////////////////////

// Parallel lanes, one output bit each
`define POOL_CHANNELS 8
// Samples held per lane before a pooled result
`define POOL_WINDOW 7
// Activation and threshold width, two's complement
`define POOL_SAMPLE_W 9

////////////////////////////////////////////////////////////////////////////
// Register bus
////////////////////////////////////////////////////////////////////////////

`define APB_ADDR_W 8
`define APB_DATA_W 32

`endif

// ==== hw/pool_thresh_pkg.sv ====
`default_nettype none

`include "pool_thresh_config.svh"

package pool_thresh_pkg;

    // One signed activation or threshold
    typedef logic signed [`POOL_SAMPLE_W-1:0] sample_t;

    // All lanes side by side, lane 0 in the low bits
    typedef logic [`POOL_CHANNELS*`POOL_SAMPLE_W-1:0] lane_bus_t;

    // One binarized bit per lane
    typedef logic [`POOL_CHANNELS-1:0] bin_vec_t;

    typedef logic [`APB_ADDR_W-1:0] apb_addr_t;
    typedef logic [`APB_DATA_W-1:0] apb_data_t;

    // Counts accepted beats up to a full window
    typedef logic [$clog2(`POOL_WINDOW+1)-1:0] fill_cnt_t;

endpackage

`default_nettype wire

// ==== hw/pool_thresh_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pool_thresh_config.svh"

module pool_thresh_top import pool_thresh_pkg::*; (
    input  wire        clk,
    input  wire        o_0_val,
    input  wire        i_psel,
    input  wire        i_penable,
    input  wire        i_pwrite,
    input  apb_addr_t  i_paddr,
    input  apb_data_t  i_pwdata,
    input  wire        i_smp_vld,
    input  lane_bus_t  i_smp,
    output apb_data_t  o_prdata,
    output logic       o_pready,
    output logic       o_pslverr,
    output bin_vec_t   o_bin,
    output logic       o_bin_vld
);

    localparam int SW = `POOL_SAMPLE_W;

    lane_bus_t thre;
    lane_bus_t win [`POOL_WINDOW];
    logic      win_vld;
    bin_vec_t  bin_vld;

    thre_apb_regs u_regs (
        .clk       (clk),
        .o_0_val   (o_0_val),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .o_prdata  (o_prdata),
        .o_pready  (o_pready),
        .o_pslverr (o_pslverr),
        .o_thre    (thre)
    );

    pool_window u_window (
        .clk       (clk),
        .o_0_val   (o_0_val),
        .i_smp_vld (i_smp_vld),
        .i_smp     (i_smp),
        .o_win     (win),
        .o_win_vld (win_vld)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Per-lane binarizers
    ////////////////////////////////////////////////////////////////////////////

    for (genvar k = 0; k < `POOL_CHANNELS; k++) begin : g_lane
        sample_t lane_win [`POOL_WINDOW];

        // Pick this lane's slice out of every window entry
        for (genvar j = 0; j < `POOL_WINDOW; j++) begin : g_tap
            assign lane_win[j] = win[j][k*SW +: SW];
        end

        chan_binarize u_bin (
            .clk       (clk),
            .o_0_val   (o_0_val),
            .i_win_vld (win_vld),
            .i_win     (lane_win),
            .i_thre    (thre[k*SW +: SW]),
            .o_bin     (o_bin[k]),
            .o_bin_vld (bin_vld[k])
        );
    end

    // All lanes share one valid, lane 0 speaks for them
    assign o_bin_vld = bin_vld[0];

endmodule

`default_nettype wire

// ==== hw/pool_window.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pool_thresh_config.svh"

module pool_window import pool_thresh_pkg::*; (
    input  wire        clk,
    input  wire        o_0_val,
    input  wire        i_smp_vld,
    input  lane_bus_t  i_smp,
    output lane_bus_t  o_win [`POOL_WINDOW],
    output logic       o_win_vld
);

    localparam int W = `POOL_WINDOW;

    ////////////////////////////////////////////////////////////////////////////
    // Sample window
    ////////////////////////////////////////////////////////////////////////////

    // Entry 0 is the oldest sample, entry W-1 the newest
    always_ff @(posedge clk or negedge o_0_val) begin
        if (!o_0_val) begin
            for (int i = 0; i < W; i++) begin
                o_win[i] <= '0;
            end
        end else if (i_smp_vld) begin
            for (int i = 0; i < W - 1; i++) begin
                o_win[i] <= o_win[i+1];
            end
            o_win[W-1] <= i_smp;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Fill and stride control
    ////////////////////////////////////////////////////////////////////////////

    fill_cnt_t fill_cnt;
    logic      stride_q;
    logic      win_full;
    logic      first_res;
    logic      res_beat;

    assign win_full  = (fill_cnt == fill_cnt_t'(W));
    // Beat that completes the first window
    assign first_res = (fill_cnt == fill_cnt_t'(W - 1));

    // After the first result, every second accepted beat gives one
    assign res_beat = first_res || (win_full && stride_q);

    always_ff @(posedge clk or negedge o_0_val) begin
        if (!o_0_val) begin
            fill_cnt <= '0;
            stride_q <= 1'b0;
        end else if (i_smp_vld) begin
            if (!win_full) begin
                fill_cnt <= fill_cnt + 1'b1;
            end
            if (first_res) begin
                stride_q <= 1'b0;
            end else if (win_full) begin
                stride_q <= !stride_q;
            end
        end
    end

    // Lines up with the window that holds the result beat
    always_ff @(posedge clk or negedge o_0_val) begin
        if (!o_0_val) begin
            o_win_vld <= 1'b0;
        end else begin
            o_win_vld <= i_smp_vld && res_beat;
        end
    end

endmodule

`default_nettype wire

// ==== hw/thre_apb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pool_thresh_config.svh"

module thre_apb_regs import pool_thresh_pkg::*; (
    input  wire        clk,
    input  wire        o_0_val,
    input  wire        i_psel,
    input  wire        i_penable,
    input  wire        i_pwrite,
    input  apb_addr_t  i_paddr,
    input  apb_data_t  i_pwdata,
    output apb_data_t  o_prdata,
    output logic       o_pready,
    output logic       o_pslverr,
    output lane_bus_t  o_thre
);

    localparam int SW     = `POOL_SAMPLE_W;
    localparam int WORD_W = `APB_ADDR_W - 2;
    localparam int LANE_W = $clog2(`POOL_CHANNELS);

    ////////////////////////////////////////////////////////////////////////////
    // Address decode
    ////////////////////////////////////////////////////////////////////////////

    logic [WORD_W-1:0] word_idx;
    logic [LANE_W-1:0] lane_sel;
    logic              in_range;
    logic              access;
    logic              wr_en;

    // Byte address to word index, one word per lane
    assign word_idx = i_paddr[`APB_ADDR_W-1:2];
    assign lane_sel = word_idx[LANE_W-1:0];
    assign in_range = (word_idx < WORD_W'(`POOL_CHANNELS));

    assign access = i_psel && i_penable;
    assign wr_en  = access && i_pwrite && in_range;

    ////////////////////////////////////////////////////////////////////////////
    // Threshold storage
    ////////////////////////////////////////////////////////////////////////////

    sample_t thre_q [`POOL_CHANNELS];

    always_ff @(posedge clk or negedge o_0_val) begin
        if (!o_0_val) begin
            for (int i = 0; i < `POOL_CHANNELS; i++) begin
                thre_q[i] <= '0;
            end
        end else if (wr_en) begin
            thre_q[lane_sel] <= i_pwdata[SW-1:0];
        end
    end

    for (genvar k = 0; k < `POOL_CHANNELS; k++) begin : g_pack
        assign o_thre[k*SW +: SW] = thre_q[k];
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read and response
    ////////////////////////////////////////////////////////////////////////////

    sample_t rd_thre;

    assign rd_thre = thre_q[lane_sel];

    // Zero wait states, data only in a valid read access phase
    assign o_pready = 1'b1;
    assign o_prdata = (access && !i_pwrite && in_range) ?
                      {{(`APB_DATA_W-SW){rd_thre[SW-1]}}, rd_thre} : '0;

    // Lanes past the last channel have no register behind them
    assign o_pslverr = access && !in_range;

endmodule

`default_nettype wire

// ==== test/pool_thresh_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module pool_thresh_assert (
    input wire clk,
    input wire o_0_val,
    input wire i_psel,
    input wire i_penable,
    input wire o_pready,
    input wire o_pslverr,
    input wire o_bin_vld
);

    // Stride of two keeps results apart
    a_vld_gap: assert property (@(posedge clk) disable iff (!o_0_val)
        o_bin_vld |=> !o_bin_vld)
        else $error("o_bin_vld high in two consecutive cycles");

    a_ready: assert property (@(posedge clk) disable iff (!o_0_val) o_pready)
        else $error("o_pready dropped low");

    a_slverr: assert property (@(posedge clk) disable iff (!o_0_val)
        o_pslverr |-> (i_psel && i_penable))
        else $error("o_pslverr high outside an APB access phase");

endmodule

bind pool_thresh_top pool_thresh_assert u_assert (
    .clk       (clk),
    .o_0_val   (o_0_val),
    .i_psel    (i_psel),
    .i_penable (i_penable),
    .o_pready  (o_pready),
    .o_pslverr (o_pslverr),
    .o_bin_vld (o_bin_vld)
);

`default_nettype wire

// ==== test/tb_pool_thresh.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pool_thresh_config.svh"

module tb_pool_thresh import pool_thresh_pkg::*; ();

    localparam int CH      = `POOL_CHANNELS;
    localparam int WIN     = `POOL_WINDOW;
    localparam int SW      = `POOL_SAMPLE_W;
    localparam int N_RAND  = 160;
    localparam int N_GAP   = 160;
    localparam int N_RW    = 40;

    // Gapped stream and APB phases bound the run length
    localparam int TOTAL_BEATS = N_RAND + N_GAP + 8 + N_RW;
    localparam int TOTAL_APB   = 6 * CH + 8;
    localparam int WATCHDOG_NS = (2 * TOTAL_BEATS + 3 * TOTAL_APB + 200) * 20;

    logic      clk = 1'b0;
    logic      o_0_val;
    logic      i_psel;
    logic      i_penable;
    logic      i_pwrite;
    apb_addr_t i_paddr;
    apb_data_t i_pwdata;
    logic      i_smp_vld;
    lane_bus_t i_smp;
    apb_data_t o_prdata;
    logic      o_pready;
    logic      o_pslverr;
    bin_vec_t  o_bin;
    logic      o_bin_vld;

    int        seed;
    string     test_name = "reset";
    int        cyc = 0;
    int        beat_n = 0;
    sample_t   mdl_win [CH][WIN];
    sample_t   mdl_thre [CH];
    sample_t   thre_set [CH];
    bin_vec_t  exp_q [$];
    int        due_q [$];

    pool_thresh_top DUT (
        .clk       (clk),
        .o_0_val   (o_0_val),
        .i_psel    (i_psel),
        .i_penable (i_penable),
        .i_pwrite  (i_pwrite),
        .i_paddr   (i_paddr),
        .i_pwdata  (i_pwdata),
        .i_smp_vld (i_smp_vld),
        .i_smp     (i_smp),
        .o_prdata  (o_prdata),
        .o_pready  (o_pready),
        .o_pslverr (o_pslverr),
        .o_bin     (o_bin),
        .o_bin_vld (o_bin_vld)
    );

    always #10 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Reference model and result checking
    ////////////////////////////////////////////////////////////////////////////

    // Max of each lane's last seven samples against its threshold
    function automatic bin_vec_t ref_bin();
        bin_vec_t res;
        int       mx;
        res = '0;
        for (int k = 0; k < CH; k++) begin
            mx = int'(mdl_win[k][0]);
            for (int j = 1; j < WIN; j++) begin
                if (int'(mdl_win[k][j]) > mx) begin
                    mx = int'(mdl_win[k][j]);
                end
            end
            res[k] = (mx >= int'(mdl_thre[k]));
        end
        return res;
    endfunction

    function automatic apb_data_t sext(input sample_t t);
        return apb_data_t'(int'(t));
    endfunction

    task automatic stop_with_failure();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_bin(input string name, input bin_vec_t exp, input bin_vec_t act);
        if (exp !== act) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_data(input string name, input apb_data_t exp, input apb_data_t act);
        if (exp !== act) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("Fail %s: expected %b, actual %b", name, exp, act);
            stop_with_failure();
        end
    endtask

    task automatic check_cycle(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("Fail %s: expected cycle %0d, actual cycle %0d", name, exp, act);
            stop_with_failure();
        end
    endtask

    // Thresholds and windows as the DUT holds them after each edge
    always @(posedge clk) begin
        int word;
        cyc++;
        if (o_0_val) begin
            word = int'(i_paddr) / 4;
            if (i_psel && i_penable && i_pwrite && word < CH) begin
                mdl_thre[word] = sample_t'(i_pwdata[SW-1:0]);
            end
            if (i_smp_vld) begin
                beat_n++;
                for (int k = 0; k < CH; k++) begin
                    for (int j = 0; j < WIN - 1; j++) begin
                        mdl_win[k][j] = mdl_win[k][j+1];
                    end
                    mdl_win[k][WIN-1] = i_smp[k*SW +: SW];
                end
                if (beat_n >= WIN && (beat_n - WIN) % 2 == 0) begin
                    exp_q.push_back(ref_bin());
                    // Output registers on the edge after the accepting one
                    due_q.push_back(cyc + 1);
                end
            end
        end
    end

    always @(negedge clk) begin
        bin_vec_t exp_v;
        int       due;
        if (o_0_val) begin
            if (o_bin_vld) begin
                if (exp_q.size() == 0) begin
                    $display("Result valid in cycle %0d with no result pending", cyc);
                    stop_with_failure();
                end
                exp_v = exp_q.pop_front();
                due   = due_q.pop_front();
                check_cycle({test_name, " latency"}, due, cyc);
                check_bin(test_name, exp_v, o_bin);
            end else if (due_q.size() != 0 && due_q[0] < cyc) begin
                $display("Result due in cycle %0d never appeared", due_q[0]);
                stop_with_failure();
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout, run still going after %0d ns", WATCHDOG_NS);
        stop_with_failure();
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                              output apb_data_t rdata, output logic err);
        i_psel    = 1'b1;
        i_penable = 1'b0;
        i_pwrite  = wr;
        i_paddr   = addr;
        i_pwdata  = wdata;
        @(negedge clk);
        i_penable = 1'b1;
        @(posedge clk);
        rdata = o_prdata;
        err   = o_pslverr;
        check_bit("apb pready", 1'b1, o_pready);
        @(negedge clk);
        i_psel    = 1'b0;
        i_penable = 1'b0;
    endtask

    task automatic read_all(input string name);
        apb_data_t rd;
        logic      err;
        for (int k = 0; k < CH; k++) begin
            apb_access(1'b0, apb_addr_t'(k * 4), '0, rd, err);
            check_data(name, sext(thre_set[k]), rd);
            check_bit({name, " pslverr"}, 1'b0, err);
        end
    endtask

    task automatic stream_beats(input int n, input logic gaps);
        int        sent;
        lane_bus_t d;
        sent = 0;
        while (sent < n) begin
            for (int k = 0; k < CH; k++) begin
                d[k*SW +: SW] = sample_t'($random(seed));
            end
            i_smp     = d;
            i_smp_vld = !gaps || (($random(seed) & 3) != 0);
            if (i_smp_vld) begin
                sent++;
            end
            @(negedge clk);
        end
        i_smp_vld = 1'b0;
    endtask

    task automatic wait_results();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        @(negedge clk);
    endtask

    initial begin
        apb_data_t rd;
        apb_data_t wd;
        logic      err;
        lane_bus_t d;
        int        v;
        seed      = 66;
        o_0_val   = 1'b0;
        i_psel    = 1'b0;
        i_penable = 1'b0;
        i_pwrite  = 1'b0;
        i_paddr   = '0;
        i_pwdata  = '0;
        i_smp_vld = 1'b0;
        i_smp     = '0;
        for (int k = 0; k < CH; k++) begin
            thre_set[k] = '0;
            mdl_thre[k] = '0;
            for (int j = 0; j < WIN; j++) begin
                mdl_win[k][j] = '0;
            end
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        o_0_val = 1'b1;
        @(negedge clk);

        check_bit("reset o_bin_vld", 1'b0, o_bin_vld);
        check_bin("reset o_bin", '0, o_bin);
        read_all("reset threshold");

        test_name = "threshold access";
        for (int k = 0; k < CH; k++) begin
            wd = apb_data_t'($random(seed));
            thre_set[k] = sample_t'(wd[SW-1:0]);
            apb_access(1'b1, apb_addr_t'(k * 4), wd, rd, err);
            check_bit("threshold write pslverr", 1'b0, err);
        end
        read_all("threshold readback");

        // Word 8 and up has no lane behind it
        for (int w = 8; w < 64; w += 13) begin
            apb_access(1'b1, apb_addr_t'(w * 4), apb_data_t'($random(seed)), rd, err);
            check_bit("out of range write pslverr", 1'b1, err);
            apb_access(1'b0, apb_addr_t'(w * 4), '0, rd, err);
            check_bit("out of range read pslverr", 1'b1, err);
            check_data("out of range read data", '0, rd);
        end
        read_all("threshold after out of range");

        test_name = "pooling full rate";
        stream_beats(N_RAND, 1'b0);
        wait_results();

        test_name = "pooling gapped";
        stream_beats(N_GAP, 1'b1);
        wait_results();

        ////////////////////////////////////////////////////////////////////////
        // Threshold boundary
        ////////////////////////////////////////////////////////////////////////

        test_name = "threshold boundary";
        for (int k = 0; k < CH; k++) begin
            thre_set[k] = sample_t'($random(seed) % 100);
            apb_access(1'b1, apb_addr_t'(k * 4), sext(thre_set[k]), rd, err);
        end
        // Even lanes peak at the threshold, odd lanes one below
        for (int b = 0; b < 8; b++) begin
            for (int k = 0; k < CH; k++) begin
                v = int'(thre_set[k]) - 1;
                if (k % 2 == 0) begin
                    v = (b == 4) ? int'(thre_set[k]) : int'(thre_set[k]) - 5;
                end
                d[k*SW +: SW] = sample_t'(v);
            end
            i_smp     = d;
            i_smp_vld = 1'b1;
            @(negedge clk);
        end
        i_smp_vld = 1'b0;
        wait_results();
        check_bin("threshold boundary bits", bin_vec_t'(8'h55), o_bin);

        test_name = "threshold rewrite";
        fork
            stream_beats(N_RW, 1'b0);
            begin
                repeat (15) @(negedge clk);
                apb_access(1'b1, apb_addr_t'(3 * 4), apb_data_t'(32'h0000_00ff), rd, err);
            end
        join
        wait_results();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire
